// File: common/crop_cfg.svh
`ifndef CROP_CFG_SVH
`define CROP_CFG_SVH

`define CROP_W        12      // position counters and margins

`define KEY_TYPE_KBD  2'd3    // kbd_type of a keyboard event

`define KEY_BKSP      8'h41
`define KEY_UP        8'h4c
`define KEY_DOWN      8'h4d
`define KEY_RIGHT     8'h4e
`define KEY_LEFT      8'h4f
`define KEY_ALT_L     8'h64   // alt press codes
`define KEY_ALT_R     8'h65
`define KEY_ALT_L_UP  8'he4   // alt release codes
`define KEY_ALT_R_UP  8'he5

`define HSTEP         4       // pixels per left/right key
`define VSTEP         1       // lines per up/down key

`define HFORCE        8       // forced blank at both line ends
`define VFORCE        3       // forced blank lines at frame end
`define HLEAD         2       // soft hblank moves ahead of the edge
`define VLEAD         1       // soft vblank moves ahead of the edge

`endif

// File: common/crop_pkg.sv
`include "crop_cfg.svh"

package crop_pkg;

	// resolution of the source raster; code 3 runs at the 28 MHz rate too
	typedef enum logic [1:0] {
		res_lo  = 2'd0,
		res_hi  = 2'd1,
		res_shr = 2'd2
	} vres_t;

	typedef enum logic [2:0] {
		key_none,
		key_clear,
		key_up,
		key_down,
		key_left,
		key_right,
		key_alt_on,
		key_alt_off
	} key_op_t;

	typedef struct packed {
		logic [`CROP_W-1:0] hbl_l;   // left margin
		logic [`CROP_W-1:0] hbl_r;   // right margin
		logic [`CROP_W-1:0] vbl_t;   // top margin
		logic [`CROP_W-1:0] vbl_b;   // bottom margin
	} crop_margins_t;

	typedef struct packed {
		crop_margins_t      margins;
		logic [`CROP_W-1:0] hsize;
		logic [`CROP_W-1:0] vsize;
		vres_t              res;
		logic [6:0]         chg;     // steps on size or res change
	} screen_info_t;

endpackage

// File: hdl/crop_keys.sv
`include "crop_cfg.svh"

module crop_keys import crop_pkg::*; (
	input  logic          clk_sys,
	input  logic          reset,
	input  logic          kms_level,
	input  logic [1:0]    kbd_type,
	input  logic [7:0]    kbd_data,
	output crop_margins_t margins
);

	localparam logic [`CROP_W-1:0] HSTEP_C = `HSTEP;
	localparam logic [`CROP_W-1:0] VSTEP_C = `VSTEP;

	logic    old_level;
	logic    alt;          // right/bottom margins selected
	logic    key_event;
	key_op_t op;

	function automatic key_op_t decode_key(input logic [7:0] code);
		case (code)
			`KEY_BKSP:     decode_key = key_clear;
			`KEY_UP:       decode_key = key_up;
			`KEY_DOWN:     decode_key = key_down;
			`KEY_LEFT:     decode_key = key_left;
			`KEY_RIGHT:    decode_key = key_right;
			`KEY_ALT_L,
			`KEY_ALT_R:    decode_key = key_alt_on;
			`KEY_ALT_L_UP,
			`KEY_ALT_R_UP: decode_key = key_alt_off;
			default:       decode_key = key_none;
		endcase
	endfunction

	// a toggle of the level marks a new event
	assign key_event = (old_level ^ kms_level) && (kbd_type == `KEY_TYPE_KBD);
	assign op        = key_event ? decode_key(kbd_data) : key_none;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_level <= 1'b0;
			alt       <= 1'b0;
			margins   <= '0;
		end else begin
			old_level <= kms_level;
			case (op)
				key_clear: margins <= '0;
				key_up: begin
					if (alt) margins.vbl_b <= margins.vbl_b + VSTEP_C;
					else     margins.vbl_t <= margins.vbl_t + VSTEP_C;
				end
				key_down: begin
					if (alt) margins.vbl_b <= margins.vbl_b - VSTEP_C;
					else     margins.vbl_t <= margins.vbl_t - VSTEP_C;
				end
				key_left: begin
					if (alt) margins.hbl_r <= margins.hbl_r + HSTEP_C;
					else     margins.hbl_l <= margins.hbl_l + HSTEP_C;
				end
				key_right: begin
					if (alt) margins.hbl_r <= margins.hbl_r - HSTEP_C;
					else     margins.hbl_l <= margins.hbl_l - HSTEP_C;
				end
				key_alt_on:  alt <= 1'b1;
				key_alt_off: alt <= 1'b0;
				default: ;   // no event or unknown code
			endcase
		end
	end

endmodule

// File: blank_gen/hblank_gen.sv
`include "crop_cfg.svh"

module hblank_gen import crop_pkg::*; (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               hs,        // active low
	input  logic               hblank,
	input  crop_margins_t      margins,
	output logic               hbl,
	output logic [`CROP_W-1:0] hsize
);

	localparam logic [`CROP_W-1:0] HLEAD_C  = `HLEAD;
	localparam logic [`CROP_W-1:0] HFORCE_C = `HFORCE;

	logic [`CROP_W-1:0] hcnt;
	logic [`CROP_W-1:0] hend;     // pixel where hblank ends
	logic [`CROP_W-1:0] hsta;     // pixel where hblank starts
	logic [`CROP_W-1:0] hmax;     // line length
	logic               old_hs;
	logic               old_hblank;
	logic               shbl;     // soft blank from the margins
	logic               fhbl;     // forced blank at the line ends

	logic               blank_end;
	logic               blank_start;
	logic               hs_fall;
	logic [`CROP_W-1:0] soft_off;
	logic [`CROP_W-1:0] soft_on;
	logic [`CROP_W-1:0] force_on;

	assign blank_end   = old_hblank & ~hblank;
	assign blank_start = ~old_hblank & hblank;
	assign hs_fall     = old_hs & ~hs;

	// edges wrap at the counter width like the counter itself
	assign soft_off = hend + margins.hbl_l - HLEAD_C;
	assign soft_on  = hsta + margins.hbl_r - HLEAD_C;
	assign force_on = hmax - HFORCE_C;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_hs     <= 1'b1;
			old_hblank <= 1'b1;
			hcnt       <= '0;
			hend       <= '0;
			hsta       <= '0;
			hmax       <= '0;
			hsize      <= '0;
			shbl       <= 1'b1;
			fhbl       <= 1'b1;
		end else begin
			old_hs     <= hs;
			old_hblank <= hblank;

			if (!hs) hcnt <= '0;  // held at zero through sync
			else     hcnt <= hcnt + 1'b1;

			if (blank_end) hend <= hcnt;
			if (blank_start) begin
				hsta  <= hcnt;
				hsize <= hcnt - hend;   // active width of this line
			end
			if (hs_fall) hmax <= hcnt;

			if (hcnt == soft_off) shbl <= 1'b0;
			if (hcnt == soft_on)  shbl <= 1'b1;

			if (hcnt == HFORCE_C) fhbl <= 1'b0;
			if (hcnt == force_on) fhbl <= 1'b1;
		end
	end

	assign hbl = fhbl | shbl | ~hs;

endmodule

// File: blank_gen/vblank_gen.sv
`include "crop_cfg.svh"

module vblank_gen import crop_pkg::*; (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               hs,          // active low
	input  logic               vs,          // active low
	input  logic               vblank_in,
	input  logic               hbl,
	input  crop_margins_t      margins,
	output logic               vblank,
	output logic [`CROP_W-1:0] vsize,
	output logic               de
);

	localparam logic [`CROP_W-1:0] VLEAD_C  = `VLEAD;
	localparam logic [`CROP_W-1:0] VFORCE_C = `VFORCE;

	logic [`CROP_W-1:0] vcnt;
	logic [`CROP_W-1:0] vend;     // line where vblank ends
	logic [`CROP_W-1:0] vsta;     // line where vblank starts
	logic [`CROP_W-1:0] vmax;     // frame height
	logic               old_hs;
	logic               old_vs;
	logic               old_vblank;
	logic               old_hbl;
	logic               svbl;
	logic               fvbl;

	logic               hs_fall;
	logic               vs_fall;
	logic               line_start;   // end of the blanked part of a line
	logic [`CROP_W-1:0] soft_off;
	logic [`CROP_W-1:0] soft_on;
	logic [`CROP_W-1:0] force_on;

	assign vblank     = vblank_in | ~vs;
	assign hs_fall    = old_hs & ~hs;
	assign vs_fall    = old_vs & ~vs;
	assign line_start = old_hbl & ~hbl;

	assign soft_off = vend + margins.vbl_t - VLEAD_C;
	assign soft_on  = vsta + margins.vbl_b - VLEAD_C;
	assign force_on = vmax - VFORCE_C;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_hs     <= 1'b1;
			old_vs     <= 1'b1;
			old_vblank <= 1'b1;
			old_hbl    <= 1'b1;
			vcnt       <= '0;
			vend       <= '0;
			vsta       <= '0;
			vmax       <= '0;
			vsize      <= '0;
			svbl       <= 1'b1;
			fvbl       <= 1'b1;
			de         <= 1'b0;
		end else begin
			old_hs     <= hs;
			old_vs     <= vs;
			old_vblank <= vblank;
			old_hbl    <= hbl;

			if (!vs)         vcnt <= '0;
			else if (hs_fall) vcnt <= vcnt + 1'b1;

			if (old_vblank & ~vblank) vend <= vcnt;
			if (~old_vblank & vblank) begin
				vsta  <= vcnt;
				vsize <= vcnt - vend;   // current field only
			end
			if (vs_fall) vmax <= vcnt;

			// vertical blank only switches between lines
			if (line_start) begin
				if (vcnt == soft_off) svbl <= 1'b0;
				if (vcnt == soft_on)  svbl <= 1'b1;
				if (vcnt == 1)        fvbl <= 1'b0;
				if (vcnt == force_on) fvbl <= 1'b1;
			end

			de <= ~hbl & ~(svbl | fvbl);
		end
	end

endmodule

// File: hdl/screen_info.sv
`include "crop_cfg.svh"

module screen_info import crop_pkg::*; (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               vblank,
	input  crop_margins_t      margins,
	input  logic [`CROP_W-1:0] hsize,
	input  logic [`CROP_W-1:0] vsize,
	input  vres_t              res,
	output screen_info_t       scr
);

	logic vbl_d1;
	logic vbl_d2;
	logic latch;
	logic changed;

	// record is taken two cycles after vblank drops
	assign latch   = vbl_d2 & ~vbl_d1;
	assign changed = (scr.res != res) || (scr.hsize != hsize) || (scr.vsize != vsize);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			vbl_d1 <= 1'b0;
			vbl_d2 <= 1'b0;
			scr    <= '0;
		end else begin
			vbl_d1 <= vblank;
			vbl_d2 <= vbl_d1;
			if (latch) begin
				scr.margins <= margins;
				scr.hsize   <= hsize;
				scr.vsize   <= vsize;
				scr.res     <= res;
				if (changed) scr.chg <= scr.chg + 1'b1;   // wraps at 7 bits
			end
		end
	end

endmodule

// File: hdl/pix_ce_gen.sv
module pix_ce_gen import crop_pkg::*; (
	input  logic  clk_sys,
	input  logic  reset,
	input  logic  vs,            // active low
	input  vres_t res,
	input  logic  scandoubler,
	output logic  ce_pix
);

	logic       old_vs;
	logic [3:0] acc;
	logic [3:0] step;            // latched at frame start
	logic [3:0] new_step;
	logic [3:0] sum;

	always_comb begin
		new_step = 4'd4;                               // 28 MHz
		if (scandoubler && res == res_lo)      new_step = 4'd1;   // 7 MHz
		else if (scandoubler && res == res_hi) new_step = 4'd2;   // 14 MHz
	end

	assign sum = acc + step;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_vs <= 1'b1;
			acc    <= '0;
			step   <= 4'd1;
			ce_pix <= 1'b0;
		end else begin
			old_vs <= vs;
			if (old_vs & ~vs) begin
				acc    <= '0;
				step   <= new_step;
				ce_pix <= 1'b0;
			end else begin
				acc    <= {1'b0, sum[2:0]};   // drop the eight on a pulse
				ce_pix <= sum[3];
			end
		end
	end

endmodule

// File: hdl/video_crop_top.sv
`include "crop_cfg.svh"

module video_crop_top import crop_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         hs,
	input  logic         vs,
	input  logic         hblank,
	input  logic         vblank_in,
	input  vres_t        res,
	input  logic         scandoubler,
	input  logic         kms_level,
	input  logic [1:0]   kbd_type,
	input  logic [7:0]   kbd_data,
	output logic         de,
	output logic         ce_pix,
	output screen_info_t scr
);

	crop_margins_t      margins;
	logic               hbl;
	logic               vblank;
	logic [`CROP_W-1:0] hsize;
	logic [`CROP_W-1:0] vsize;

	crop_keys u_keys (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.kms_level (kms_level),
		.kbd_type  (kbd_type),
		.kbd_data  (kbd_data),
		.margins   (margins)
	);

	hblank_gen u_hblank (
		.clk_sys (clk_sys),
		.reset   (reset),
		.hs      (hs),
		.hblank  (hblank),
		.margins (margins),
		.hbl     (hbl),
		.hsize   (hsize)
	);

	vblank_gen u_vblank (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.hs        (hs),
		.vs        (vs),
		.vblank_in (vblank_in),
		.hbl       (hbl),
		.margins   (margins),
		.vblank    (vblank),
		.vsize     (vsize),
		.de        (de)
	);

	screen_info u_scr (
		.clk_sys (clk_sys),
		.reset   (reset),
		.vblank  (vblank),
		.margins (margins),
		.hsize   (hsize),
		.vsize   (vsize),
		.res     (res),
		.scr     (scr)
	);

	pix_ce_gen u_ce (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.vs          (vs),
		.res         (res),
		.scandoubler (scandoubler),
		.ce_pix      (ce_pix)
	);

endmodule

// File: tests/crop_clk_gen.sv
module crop_clk_gen (
	output logic clk_sys,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;   // 10 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
	end

endmodule

// File: tests/crop_props.sv
module crop_props import crop_pkg::*; (
	input logic         clk_sys,
	input logic         reset,
	input logic         hs,
	input logic         de,
	input logic         ce_pix,
	input logic         vblank,
	input screen_info_t scr
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_cnt = 0;   // read by the testbench at the end

	a_de_in_sync: assert property (@(posedge clk_sys) disable iff (reset) !hs |-> !de)
		else begin $error("de high during hsync"); fail_cnt++; end

	a_ce_single: assert property (@(posedge clk_sys) disable iff (reset) ce_pix |=> !ce_pix)
		else begin $error("ce_pix high on two cycles in a row"); fail_cnt++; end

	// record is latched two cycles after the vblank fall
	a_res_latch: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(scr.res) |-> ($past(vblank, 3) && !$past(vblank, 2)))
		else begin $error("scr.res changed outside the latch cycle"); fail_cnt++; end

endmodule

bind video_crop_top crop_props u_props (
	.clk_sys (clk_sys),
	.reset   (reset),
	.hs      (hs),
	.de      (de),
	.ce_pix  (ce_pix),
	.vblank  (vblank),
	.scr     (scr)
);

// File: tests/crop_tb.sv
`include "crop_cfg.svh"

module crop_tb import crop_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int    NFRAMES = 20;
	localparam int    VTOTAL  = 40;   // lines per frame, fixed
	localparam int    HS_W    = 4;
	localparam longint WDOG_NS = longint'(NFRAMES + 5) * VTOTAL * 300 * 10 + 20000;

	logic         clk_sys, reset;
	logic         hs, vs, hblank, vblank_in, scandoubler;
	logic         kms_level, de, ce_pix;
	logic [1:0]   kbd_type;
	logic [7:0]   kbd_data;
	vres_t        res;
	screen_info_t scr;

	crop_margins_t      model_m;
	logic               model_alt;
	screen_info_t       exp_scr;
	int                 prev_vact;
	logic [`CROP_W-1:0] de_count;
	logic [7:0]         key_code [8];
	logic [1:0]         key_type [8];
	int                 key_n;
	logic [7:0]         key_table [10] = '{`KEY_BKSP, `KEY_UP, `KEY_DOWN, `KEY_LEFT,
		`KEY_RIGHT, `KEY_ALT_L, `KEY_ALT_R, `KEY_ALT_L_UP, `KEY_ALT_R_UP, 8'h10};

	crop_clk_gen u_clk (.clk_sys(clk_sys), .reset(reset));
	video_crop_top uut (.*);

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_scr(input screen_info_t got, input screen_info_t exp);
		if (got !== exp) begin
			$display("got m=%h hsize=%0d vsize=%0d res=%0d chg=%0d", got.margins, got.hsize,
				got.vsize, got.res, got.chg);
			$display("exp m=%h hsize=%0d vsize=%0d res=%0d chg=%0d", exp.margins, exp.hsize,
				exp.vsize, exp.res, exp.chg);
			fail_now($sformatf("ERR %0t: screen record mismatch", $time));
		end
	endtask

	task automatic check_count(input logic [`CROP_W-1:0] got, exp, input string what);
		if (got !== exp)
			fail_now($sformatf("ERR %0t: %s got %0d expected %0d", $time, what, got, exp));
	endtask

	task automatic check_ce(input int got, exp);
		if (got != exp)
			fail_now($sformatf("ERR %0t: ce_pix spacing %0d expected %0d", $time, got, exp));
	endtask

	task automatic check_level(input logic got, exp, input string what);
		if (got !== exp)
			fail_now($sformatf("ERR %0t: %s is %b expected %b", $time, what, got, exp));
	endtask

	// reference for the margin keys
	task automatic model_key(input logic [1:0] t, input logic [7:0] c);
		if (t != `KEY_TYPE_KBD) return;
		case (c)
			`KEY_BKSP:  model_m = '0;
			`KEY_UP:    if (model_alt) model_m.vbl_b += `VSTEP; else model_m.vbl_t += `VSTEP;
			`KEY_DOWN:  if (model_alt) model_m.vbl_b -= `VSTEP; else model_m.vbl_t -= `VSTEP;
			`KEY_LEFT:  if (model_alt) model_m.hbl_r += `HSTEP; else model_m.hbl_l += `HSTEP;
			`KEY_RIGHT: if (model_alt) model_m.hbl_r -= `HSTEP; else model_m.hbl_l -= `HSTEP;
			`KEY_ALT_L, `KEY_ALT_R:       model_alt = 1'b1;
			`KEY_ALT_L_UP, `KEY_ALT_R_UP: model_alt = 1'b0;
			default: ;
		endcase
	endtask

	task automatic drive_frame(input int len, hb_end, hb_sta, v_top, v_act,
			input vres_t r, input logic sd);
		int m;
		int k;
		m        = v_top + v_act / 2;   // mid-frame line for the de count
		k        = 0;
		de_count = '0;
		for (int line = 0; line < VTOTAL; line++) begin
			for (int p = 0; p < len; p++) begin
				@(posedge clk_sys);
				if (line == m) de_count += de;
				if (line == v_top + 1 && p == 0) begin
					if (hb_sta - hb_end != exp_scr.hsize || prev_vact != exp_scr.vsize ||
							r != exp_scr.res)
						exp_scr.chg++;
					exp_scr.margins = model_m;
					exp_scr.hsize   = hb_sta - hb_end;
					exp_scr.vsize   = prev_vact;   // vsize lags one frame
					exp_scr.res     = r;
					check_scr(scr, exp_scr);
					prev_vact = v_act;
				end
				hs        <= (p >= HS_W);
				vs        <= (line != 0);
				hblank    <= !(p >= hb_end && p < hb_sta);
				vblank_in <= !(line >= v_top && line < v_top + v_act);
				if (line == 0 && p == 0) begin
					res         <= r;
					scandoubler <= sd;
				end
				if (line == 2 && k < key_n && p == 20 + 12 * k) begin   // keys in vblank
					kbd_type  <= key_type[k];
					kbd_data  <= key_code[k];
					kms_level <= ~kms_level;
					model_key(key_type[k], key_code[k]);
					k++;
				end
			end
		end
	endtask

	// pixel enable spacing, restarted at every vs fall
	logic mon_vs = 1'b1;
	logic ce_armed, ce_seen;
	int   ce_cyc, ce_last, ce_exp;

	always @(posedge clk_sys) begin
		if (reset) begin
			ce_armed = 1'b0;
			ce_seen  = 1'b0;
		end else begin
			if (mon_vs && !vs) begin
				if (ce_armed && !ce_seen)
					fail_now("ce_pix did not pulse at all during the last frame");
				ce_armed = 1'b1;
				ce_seen  = 1'b0;
				ce_cyc   = 0;
				if (scandoubler && res == res_lo)      ce_exp = 8;
				else if (scandoubler && res == res_hi) ce_exp = 4;
				else                                   ce_exp = 2;
			end else if (ce_armed) begin
				ce_cyc++;
				if (ce_pix) begin
					if (ce_seen) check_ce(ce_cyc - ce_last, ce_exp);
					ce_last = ce_cyc;
					ce_seen = 1'b1;
				end
			end
			mon_vs = vs;
		end
	end

	initial begin
		#(WDOG_NS);
		fail_now("watchdog timeout, the raster did not finish in time");
	end

	initial begin
		int   len, hb_end, hb_sta, v_top, v_act, n;
		vres_t r;
		logic  sd;
		logic [`CROP_W-1:0] width_a;
		void'($urandom(137));
		hs          = 1'b1;
		vs          = 1'b1;
		hblank      = 1'b1;
		vblank_in   = 1'b1;
		res         = res_lo;
		scandoubler = 1'b1;
		kms_level   = 1'b0;
		kbd_type    = 2'd0;
		kbd_data    = 8'd0;
		model_m     = '0;
		model_alt   = 1'b0;
		exp_scr     = '0;
		prev_vact   = 0;
		key_n       = 0;

		@(negedge reset);
		@(posedge clk_sys);
		check_level(de, 1'b0, "de after reset");
		check_level(ce_pix, 1'b0, "ce_pix after reset");
		check_scr(scr, '0);

		for (int f = 0; f < NFRAMES; f++) begin
			if (f == 0 || $urandom % 2) begin   // otherwise repeat the last geometry
				len    = 200 + $urandom % 101;
				hb_end = 16 + $urandom % 40;
				hb_sta = len - 16 - $urandom % 40;
				v_top  = 5 + $urandom % 4;
				v_act  = 15 + $urandom % 10;
				r      = vres_t'($urandom % 4);
				sd     = $urandom % 2;
			end
			key_n = (f == 0) ? 0 : $urandom % 6;
			for (int i = 0; i < key_n; i++) begin
				key_code[i] = key_table[$urandom % 10];
				key_type[i] = ($urandom % 5 == 0) ? 2'd1 : `KEY_TYPE_KBD;
			end
			drive_frame(len, hb_end, hb_sta, v_top, v_act, r, sd);
		end

		// de width against the left margin, fixed geometry
		key_n       = 2;
		key_code[0] = `KEY_ALT_L_UP;
		key_code[1] = `KEY_BKSP;
		key_type[0] = `KEY_TYPE_KBD;
		key_type[1] = `KEY_TYPE_KBD;
		drive_frame(250, 40, 200, 6, 24, res_lo, 1'b1);
		key_n = 0;
		drive_frame(250, 40, 200, 6, 24, res_lo, 1'b1);
		width_a = de_count;
		n       = 1 + $urandom % 5;
		key_n   = n;
		for (int i = 0; i < n; i++) begin
			key_code[i] = `KEY_LEFT;
			key_type[i] = `KEY_TYPE_KBD;
		end
		drive_frame(250, 40, 200, 6, 24, res_lo, 1'b1);
		check_count(de_count, width_a - `HSTEP * n, "de width");

		repeat (10) @(posedge clk_sys);
		if (uut.u_props.fail_cnt == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			fail_now("a concurrent assertion failed");
		end
	end

endmodule

// File: files.f
+incdir+common
common/crop_pkg.sv
hdl/crop_keys.sv
blank_gen/hblank_gen.sv
blank_gen/vblank_gen.sv
hdl/screen_info.sv
hdl/pix_ce_gen.sv
hdl/video_crop_top.sv
tests/crop_clk_gen.sv
tests/crop_props.sv
tests/crop_tb.sv

// File: Bender.yml
package:
  name: video_crop

sources:
  - include_dirs:
      - common
    files:
      - common/crop_pkg.sv
      - hdl/crop_keys.sv
      - blank_gen/hblank_gen.sv
      - blank_gen/vblank_gen.sv
      - hdl/screen_info.sv
      - hdl/pix_ce_gen.sv
      - hdl/video_crop_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/crop_clk_gen.sv
      - tests/crop_props.sv
      - tests/crop_tb.sv
